// ==== router_macros.svh ====
`ifndef ROUTER_MACROS_SVH
`define ROUTER_MACROS_SVH

// widths
`define ROUTER_NODE_ID_W 4
`define ROUTER_PAYLOAD_W 16

// table sizes
`define ROUTER_TABLE_DEPTH 16
`define ROUTER_NUM_NEIGHBORS 4

// neighbor expiry
`define ROUTER_EXPIRE_CYCLES 64
`define ROUTER_EXPIRE_W 7

// reserved ids
`define ROUTER_ROOT_ID 0
`define ROUTER_UNASSIGNED_ID 15

`endif

// ==== router_pkg.sv ====
`include "router_macros.svh"

package router_pkg;

    typedef logic [`ROUTER_NODE_ID_W-1:0] node_id_t;
    typedef logic [`ROUTER_PAYLOAD_W-1:0] payload_t;
    typedef logic [`ROUTER_EXPIRE_W-1:0] expire_cnt_t;

    typedef logic [1:0] flit_kind_t;

    localparam flit_kind_t FLIT_DATA      = 2'd0;
    localparam flit_kind_t FLIT_JOIN_REQ  = 2'd1;
    localparam flit_kind_t FLIT_JOIN_ACK  = 2'd2;
    localparam flit_kind_t FLIT_ROUTE_SET = 2'd3;

    // join ack carries the assigned id in the low payload bits
    // route set keys the table on dst with the next hop in the low payload bits
    typedef struct packed {
        flit_kind_t kind;
        node_id_t   src;
        node_id_t   dst;
        payload_t   payload;
    } flit_t;

    typedef struct packed {
        flit_t    flit;
        logic     is_data;
        logic     is_self;
        logic     is_join_ack;
        logic     is_route_set;
        node_id_t hop;
    } decoded_t;

    typedef enum logic [1:0] {
        JOIN_INIT,
        JOIN_SEND_REQ,
        JOIN_WAIT_ACK,
        JOIN_NORMAL
    } join_state_t;

endpackage

// ==== join_fsm.sv ====
`timescale 1ns/1ps
`include "router_macros.svh"

module join_fsm (
    input  logic                     nocclk,
    input  logic                     rst_n,
    input  router_pkg::decoded_t     dec,
    input  logic                     dec_take,
    input  logic                     join_req_taken,
    output logic                     join_req,
    output logic                     joined,
    output router_pkg::node_id_t     this_node_id,
    output router_pkg::node_id_t     parent_id,
    output router_pkg::join_state_t  join_state
);

    import router_pkg::*;

    join_state_t state;
    node_id_t    node_id_q;
    node_id_t    parent_q;
    logic        ack_take;

    always_comb begin
        ack_take = dec_take && dec.is_join_ack;
        join_req = (state == JOIN_SEND_REQ);
        joined = (state == JOIN_NORMAL);
        this_node_id = node_id_q;
        parent_id = parent_q;
        join_state = state;
    end

    always_ff @(posedge nocclk) begin
        if (!rst_n) begin
            state <= JOIN_INIT;
            node_id_q <= node_id_t'(`ROUTER_UNASSIGNED_ID);
            parent_q <= node_id_t'(`ROUTER_ROOT_ID);
        end else begin
            case (state)
                JOIN_INIT: begin
                    state <= JOIN_SEND_REQ;
                end
                JOIN_SEND_REQ: begin
                    // request sits in the output register now
                    if (join_req_taken) begin
                        state <= JOIN_WAIT_ACK;
                    end
                end
                JOIN_WAIT_ACK: begin
                    if (ack_take) begin
                        state <= JOIN_NORMAL;
                        node_id_q <= dec.hop;
                        parent_q <= dec.flit.src;
                    end
                end
                JOIN_NORMAL: begin
                end
                default: begin
                    state <= JOIN_INIT;
                end
            endcase
        end
    end

endmodule

// ==== neighbor_timer.sv ====
`timescale 1ns/1ps
`include "router_macros.svh"

module neighbor_timer (
    input  logic                 nocclk,
    input  logic                 rst_n,
    input  logic                 reg_valid,
    input  router_pkg::node_id_t reg_id,
    input  logic                 heard_valid,
    input  router_pkg::node_id_t heard_node_id,
    output logic                 expire_valid,
    output router_pkg::node_id_t expire_id
);

    import router_pkg::*;

    localparam int NUM = `ROUTER_NUM_NEIGHBORS;
    localparam int IDX_W = $clog2(NUM);
    localparam expire_cnt_t EXPIRE_AT = expire_cnt_t'(`ROUTER_EXPIRE_CYCLES);

    node_id_t         slot_id [NUM];
    expire_cnt_t      slot_cnt [NUM];
    logic [NUM-1:0]   slot_valid;
    logic [NUM-1:0]   refresh;
    logic [NUM-1:0]   reg_hit;
    logic             free_found;
    logic [IDX_W-1:0] free_idx;
    logic             exp_found;
    logic [IDX_W-1:0] exp_idx;

    always_comb begin
        free_found = 1'b0;
        free_idx = '0;
        exp_found = 1'b0;
        exp_idx = '0;
        for (int i = 0; i < NUM; i++) begin
            reg_hit[i] = slot_valid[i] && reg_valid && (slot_id[i] == reg_id);
            refresh[i] = reg_hit[i] ||
                         (slot_valid[i] && heard_valid && (slot_id[i] == heard_node_id));
            if (!slot_valid[i] && !free_found) begin
                free_found = 1'b1;
                free_idx = IDX_W'(i);
            end
            // one expiry per cycle while the rest wait saturated
            if (slot_valid[i] && !refresh[i] && slot_cnt[i] == EXPIRE_AT && !exp_found) begin
                exp_found = 1'b1;
                exp_idx = IDX_W'(i);
            end
        end
    end

    always_ff @(posedge nocclk) begin
        if (!rst_n) begin
            slot_valid <= '0;
            expire_valid <= 1'b0;
            expire_id <= '0;
        end else begin
            expire_valid <= exp_found;
            expire_id <= slot_id[exp_idx];
            if (exp_found) begin
                slot_valid[exp_idx] <= 1'b0;
            end
            if (reg_valid && !(|reg_hit) && free_found) begin
                slot_valid[free_idx] <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // slot payload and counters

    always_ff @(posedge nocclk) begin
        for (int i = 0; i < NUM; i++) begin
            if (refresh[i]) begin
                slot_cnt[i] <= '0;
            end else if (slot_cnt[i] != EXPIRE_AT) begin
                slot_cnt[i] <= slot_cnt[i] + 1'b1;
            end
        end
        if (reg_valid && !(|reg_hit) && free_found) begin
            slot_id[free_idx] <= reg_id;
            slot_cnt[free_idx] <= '0;
        end
    end

endmodule

// ==== flit_decoder.sv ====
`timescale 1ns/1ps
`include "router_macros.svh"

module flit_decoder (
    input  logic                 nocclk,
    input  logic                 rst_n,
    input  router_pkg::flit_t    in_flit,
    input  logic                 in_flit_valid,
    input  logic                 accept_en,
    input  logic                 stage2_free,
    input  router_pkg::node_id_t this_node_id,
    output logic                 in_flit_ready,
    output router_pkg::decoded_t dec,
    output logic                 dec_valid,
    output logic                 dec_take
);

    import router_pkg::*;

    decoded_t dec_q;
    decoded_t dec_next;
    logic     advance;

    always_comb begin
        advance = !dec_valid || stage2_free;
        in_flit_ready = accept_en && advance;
        dec_take = dec_valid && stage2_free;
    end

    always_comb begin
        dec_next.flit = in_flit;
        dec_next.is_data = (in_flit.kind == FLIT_DATA);
        dec_next.is_self = 1'b0;
        dec_next.is_join_ack = (in_flit.kind == FLIT_JOIN_ACK);
        dec_next.is_route_set = (in_flit.kind == FLIT_ROUTE_SET);
        dec_next.hop = in_flit.payload[`ROUTER_NODE_ID_W-1:0];
    end

    always_ff @(posedge nocclk) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else if (advance) begin
            dec_valid <= in_flit_valid && accept_en;
        end
    end

    always_ff @(posedge nocclk) begin
        if (in_flit_valid && in_flit_ready) begin
            dec_q <= dec_next;
        end
    end

    // compared late so an id taken from the flit just ahead still counts
    always_comb begin
        dec = dec_q;
        dec.is_self = dec_q.is_data && (dec_q.flit.dst == this_node_id);
    end

endmodule

// ==== route_table.sv ====
`timescale 1ns/1ps
`include "router_macros.svh"

module route_table (
    input  logic                 nocclk,
    input  logic                 rst_n,
    input  router_pkg::decoded_t dec,
    input  logic                 dec_take,
    input  logic                 expire_valid,
    input  router_pkg::node_id_t expire_id,
    output router_pkg::node_id_t next_hop,
    output logic                 next_hop_valid
);

    import router_pkg::*;

    localparam int DEPTH = `ROUTER_TABLE_DEPTH;

    node_id_t         hop_q [DEPTH];
    logic [DEPTH-1:0] valid_q;
    logic             wr_en;

    always_comb begin
        wr_en = dec_take && dec.is_route_set && !expire_valid;
        next_hop = hop_q[dec.flit.dst];
        next_hop_valid = valid_q[dec.flit.dst];
    end

    always_ff @(posedge nocclk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (expire_valid) begin
            // drop every route through the lost neighbor
            for (int i = 0; i < DEPTH; i++) begin
                if (valid_q[i] && hop_q[i] == expire_id) begin
                    valid_q[i] <= 1'b0;
                end
            end
        end else if (wr_en) begin
            valid_q[dec.flit.dst] <= 1'b1;
        end
    end

    always_ff @(posedge nocclk) begin
        if (wr_en) begin
            hop_q[dec.flit.dst] <= dec.hop;
        end
    end

endmodule

// ==== flit_steer.sv ====
`timescale 1ns/1ps
`include "router_macros.svh"

module flit_steer (
    input  logic                 nocclk,
    input  logic                 rst_n,
    input  router_pkg::decoded_t dec,
    input  logic                 dec_valid,
    input  router_pkg::node_id_t next_hop,
    input  logic                 next_hop_valid,
    input  router_pkg::node_id_t parent_id,
    input  logic                 joined,
    input  logic                 join_req,
    output logic                 join_req_taken,
    output logic                 stage2_free,
    output router_pkg::flit_t    cpu_flit,
    output logic                 cpu_flit_valid,
    input  logic                 cpu_flit_ready,
    output router_pkg::flit_t    fwd_flit,
    output router_pkg::node_id_t fwd_next_hop,
    output logic                 fwd_flit_valid,
    input  logic                 fwd_flit_ready
);

    import router_pkg::*;

    flit_t    out_flit;
    node_id_t out_hop;
    logic     out_valid;
    logic     out_to_cpu;
    logic     out_free;
    logic     load_data;
    flit_t    join_flit;

    always_comb begin
        out_free = !out_valid || (out_to_cpu ? cpu_flit_ready : fwd_flit_ready);
        join_req_taken = out_free && join_req;
        stage2_free = out_free && !join_req;
        // system flits and unjoined data just fall out of stage 1
        load_data = stage2_free && dec_valid && dec.is_data && joined;

        join_flit.kind = FLIT_JOIN_REQ;
        join_flit.src = node_id_t'(`ROUTER_UNASSIGNED_ID);
        join_flit.dst = node_id_t'(`ROUTER_ROOT_ID);
        join_flit.payload = '0;
    end

    always_ff @(posedge nocclk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_to_cpu <= 1'b0;
        end else if (out_free) begin
            out_valid <= join_req || load_data;
            out_to_cpu <= !join_req && dec.is_self;
        end
    end

    always_ff @(posedge nocclk) begin
        if (join_req_taken) begin
            out_flit <= join_flit;
            out_hop <= node_id_t'(`ROUTER_ROOT_ID);
        end else if (load_data) begin
            out_flit <= dec.flit;
            out_hop <= next_hop_valid ? next_hop : parent_id;
        end
    end

    ////////////////////////////////////////
    // output split

    always_comb begin
        cpu_flit = out_flit;
        fwd_flit = out_flit;
        fwd_next_hop = out_hop;
        cpu_flit_valid = out_valid && out_to_cpu;
        fwd_flit_valid = out_valid && !out_to_cpu;
    end

endmodule

// ==== router_node.sv ====
`timescale 1ns/1ps

module router_node (
    input  logic                 nocclk,
    input  logic                 rst_n,
    input  router_pkg::flit_t    in_flit,
    input  logic                 in_flit_valid,
    output logic                 in_flit_ready,
    input  router_pkg::node_id_t heard_node_id,
    input  logic                 heard_valid,
    output router_pkg::flit_t    cpu_flit,
    output logic                 cpu_flit_valid,
    input  logic                 cpu_flit_ready,
    output router_pkg::flit_t    fwd_flit,
    output router_pkg::node_id_t fwd_next_hop,
    output logic                 fwd_flit_valid,
    input  logic                 fwd_flit_ready,
    output router_pkg::node_id_t this_node_id,
    output logic                 joined
);

    import router_pkg::*;

    decoded_t    dec;
    logic        dec_valid;
    logic        dec_take;
    logic        stage2_free;
    logic        accept_en;
    node_id_t    next_hop;
    logic        next_hop_valid;
    logic        join_req;
    logic        join_req_taken;
    node_id_t    parent_id;
    join_state_t join_state;
    logic        reg_valid;
    logic        expire_valid;
    node_id_t    expire_id;

    assign accept_en = (join_state == JOIN_WAIT_ACK) || (join_state == JOIN_NORMAL);
    assign reg_valid = dec_take && dec.is_route_set;

    ////////////////////////////////////////
    // stage 1

    flit_decoder flit_decoder0 (
        .nocclk(nocclk),
        .rst_n(rst_n),
        .in_flit(in_flit),
        .in_flit_valid(in_flit_valid),
        .accept_en(accept_en),
        .stage2_free(stage2_free),
        .this_node_id(this_node_id),
        .in_flit_ready(in_flit_ready),
        .dec(dec),
        .dec_valid(dec_valid),
        .dec_take(dec_take)
    );

    route_table route_table0 (
        .nocclk(nocclk),
        .rst_n(rst_n),
        .dec(dec),
        .dec_take(dec_take),
        .expire_valid(expire_valid),
        .expire_id(expire_id),
        .next_hop(next_hop),
        .next_hop_valid(next_hop_valid)
    );

    ////////////////////////////////////////
    // stage 2

    flit_steer flit_steer0 (
        .nocclk(nocclk),
        .rst_n(rst_n),
        .dec(dec),
        .dec_valid(dec_valid),
        .next_hop(next_hop),
        .next_hop_valid(next_hop_valid),
        .parent_id(parent_id),
        .joined(joined),
        .join_req(join_req),
        .join_req_taken(join_req_taken),
        .stage2_free(stage2_free),
        .cpu_flit(cpu_flit),
        .cpu_flit_valid(cpu_flit_valid),
        .cpu_flit_ready(cpu_flit_ready),
        .fwd_flit(fwd_flit),
        .fwd_next_hop(fwd_next_hop),
        .fwd_flit_valid(fwd_flit_valid),
        .fwd_flit_ready(fwd_flit_ready)
    );

    ////////////////////////////////////////
    // control

    join_fsm join_fsm0 (
        .nocclk(nocclk),
        .rst_n(rst_n),
        .dec(dec),
        .dec_take(dec_take),
        .join_req_taken(join_req_taken),
        .join_req(join_req),
        .joined(joined),
        .this_node_id(this_node_id),
        .parent_id(parent_id),
        .join_state(join_state)
    );

    neighbor_timer neighbor_timer0 (
        .nocclk(nocclk),
        .rst_n(rst_n),
        .reg_valid(reg_valid),
        .reg_id(dec.hop),
        .heard_valid(heard_valid),
        .heard_node_id(heard_node_id),
        .expire_valid(expire_valid),
        .expire_id(expire_id)
    );

endmodule

// ==== router_node_asserts.sv ====
`timescale 1ns/1ps

module router_node_asserts (
    input logic                 nocclk,
    input logic                 rst_n,
    input router_pkg::flit_t    cpu_flit,
    input logic                 cpu_flit_valid,
    input logic                 cpu_flit_ready,
    input router_pkg::flit_t    fwd_flit,
    input router_pkg::node_id_t fwd_next_hop,
    input logic                 fwd_flit_valid,
    input logic                 fwd_flit_ready
);

    int fail_count = 0;

    // a waiting flit stays put until taken
    cpu_hold: assert property (@(posedge nocclk) disable iff (!rst_n)
        cpu_flit_valid && !cpu_flit_ready |=> cpu_flit_valid && $stable(cpu_flit))
        else begin
            $error("cpu flit changed or dropped before it was taken");
            fail_count++;
        end

    fwd_hold: assert property (@(posedge nocclk) disable iff (!rst_n)
        fwd_flit_valid && !fwd_flit_ready |=>
            fwd_flit_valid && $stable(fwd_flit) && $stable(fwd_next_hop))
        else begin
            $error("forward flit changed or dropped before it was taken");
            fail_count++;
        end

    reset_quiet: assert property (@(posedge nocclk)
        !rst_n |=> !cpu_flit_valid && !fwd_flit_valid)
        else begin
            $error("output valid high during reset");
            fail_count++;
        end

    // one output register feeds both ports
    one_port: assert property (@(posedge nocclk) disable iff (!rst_n)
        !(cpu_flit_valid && fwd_flit_valid))
        else begin
            $error("cpu and forward valid high together");
            fail_count++;
        end

endmodule

bind router_node router_node_asserts asserts0 (.*);

// ==== tb_router_node.sv ====
`timescale 1ns/1ps
`include "router_macros.svh"

module tb_router_node;

    import router_pkg::*;

    localparam int SEED = 26641;
    localparam int WAIT_LIMIT = 2000;
    localparam int NUM_RANDOM = 200;
    localparam int NUM_IDS = 1 << `ROUTER_NODE_ID_W;

    typedef struct packed {
        flit_t    flit;
        node_id_t hop;
    } fwd_item_t;

    typedef struct packed {
        logic     to_cpu;
        node_id_t hop;
    } route_res_t;

    typedef struct packed {
        logic [`ROUTER_TABLE_DEPTH-1:0]     valid;
        node_id_t [`ROUTER_TABLE_DEPTH-1:0] hop;
    } route_model_t;

    logic     nocclk = 1'b0;
    logic     rst_n;
    flit_t    in_flit;
    logic     in_flit_valid;
    logic     in_flit_ready;
    node_id_t heard_node_id;
    logic     heard_valid;
    flit_t    cpu_flit;
    logic     cpu_flit_valid;
    logic     cpu_flit_ready;
    flit_t    fwd_flit;
    node_id_t fwd_next_hop;
    logic     fwd_flit_valid;
    logic     fwd_flit_ready;
    node_id_t this_node_id;
    logic     joined;

    int seed = SEED;
    int ready_seed = SEED + 1;
    logic keep_6 = 1'b0;
    logic keep_9 = 1'b0;
    logic rand_ready = 1'b0;
    logic [7:0] heard_tick = '0;

    // expected behavior of the node
    logic               model_joined;
    node_id_t           model_id;
    node_id_t           model_parent;
    route_model_t       model_tab;
    logic [NUM_IDS-1:0] model_alive;
    flit_t              cpu_q [$];
    fwd_item_t          fwd_q [$];

    always #5 nocclk = ~nocclk;

    router_node dut0 (
        .nocclk(nocclk),
        .rst_n(rst_n),
        .in_flit(in_flit),
        .in_flit_valid(in_flit_valid),
        .in_flit_ready(in_flit_ready),
        .heard_node_id(heard_node_id),
        .heard_valid(heard_valid),
        .cpu_flit(cpu_flit),
        .cpu_flit_valid(cpu_flit_valid),
        .cpu_flit_ready(cpu_flit_ready),
        .fwd_flit(fwd_flit),
        .fwd_next_hop(fwd_next_hop),
        .fwd_flit_valid(fwd_flit_valid),
        .fwd_flit_ready(fwd_flit_ready),
        .this_node_id(this_node_id),
        .joined(joined)
    );

    ////////////////////////////////////////
    // helpers

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got == exp) else begin
            stop_with_error($sformatf("** Error: %s is 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic next_cycle();
        @(posedge nocclk);
        #1;
    endtask

    function automatic flit_t make_flit(input flit_kind_t kind, input node_id_t src,
                                        input node_id_t dst, input payload_t payload);
        flit_t f;
        f.kind = kind;
        f.src = src;
        f.dst = dst;
        f.payload = payload;
        return f;
    endfunction

    // own id goes to the cpu, a live route wins, else the parent
    function automatic route_res_t predict_route(input flit_t f, input node_id_t my_id,
                                                 input node_id_t parent,
                                                 input route_model_t tab,
                                                 input logic [NUM_IDS-1:0] alive);
        route_res_t r;
        r.to_cpu = (f.dst == my_id);
        if (tab.valid[f.dst] && alive[tab.hop[f.dst]]) begin
            r.hop = tab.hop[f.dst];
        end else begin
            r.hop = parent;
        end
        return r;
    endfunction

    task automatic track_flit(input flit_t f);
        route_res_t r;
        fwd_item_t  item;
        node_id_t   low;
        low = f.payload[`ROUTER_NODE_ID_W-1:0];
        case (f.kind)
            FLIT_DATA: begin
                if (model_joined) begin
                    r = predict_route(f, model_id, model_parent, model_tab, model_alive);
                    if (r.to_cpu) begin
                        cpu_q.push_back(f);
                    end else begin
                        item.flit = f;
                        item.hop = r.hop;
                        fwd_q.push_back(item);
                    end
                end
            end
            FLIT_ROUTE_SET: begin
                model_tab.valid[f.dst] = 1'b1;
                model_tab.hop[f.dst] = low;
                model_alive[low] = 1'b1;
            end
            FLIT_JOIN_ACK: begin
                if (!model_joined) begin
                    model_joined = 1'b1;
                    model_id = low;
                    model_parent = f.src;
                end
            end
            default: begin
            end
        endcase
    endtask

    task automatic send_flit(input flit_t f);
        int   waited;
        logic taken;
        in_flit = f;
        in_flit_valid = 1'b1;
        waited = 0;
        taken = 1'b0;
        while (!taken) begin
            @(negedge nocclk);
            taken = in_flit_ready;
            next_cycle();
            waited++;
            if (!taken && waited > WAIT_LIMIT) begin
                stop_with_error("input flit was never accepted");
            end
        end
        in_flit_valid = 1'b0;
        track_flit(f);
    endtask

    task automatic send_random(input logic with_system);
        logic [31:0] rnd;
        node_id_t    hop;
        flit_t       f;
        rnd = $random(seed);
        hop = rnd[27] ? node_id_t'(9) : node_id_t'(6);
        if (with_system && rnd[31:29] == 3'd0) begin
            if (rnd[28]) begin
                f = make_flit(FLIT_ROUTE_SET, rnd[3:0], rnd[7:4], {rnd[23:12], hop});
            end else begin
                f = make_flit(FLIT_JOIN_ACK, rnd[3:0], rnd[7:4], rnd[23:8]);
            end
        end else begin
            f = make_flit(FLIT_DATA, rnd[3:0], rnd[7:4], rnd[23:8]);
        end
        send_flit(f);
    endtask

    // keys 1 2 4 through neighbor 6, keys 7 8 10 through neighbor 9
    task automatic install_routes();
        node_id_t keys [6];
        keys = '{4'd1, 4'd2, 4'd4, 4'd7, 4'd8, 4'd10};
        for (int k = 0; k < 6; k++) begin
            send_flit(make_flit(FLIT_ROUTE_SET, 4'd3, keys[k], (k < 3) ? 16'd6 : 16'd9));
        end
    endtask

    task automatic wait_joined();
        int waited;
        waited = 0;
        while (!joined) begin
            next_cycle();
            waited++;
            if (waited > WAIT_LIMIT) begin
                stop_with_error("joined never rose after the join acknowledge");
            end
        end
    endtask

    task automatic wait_outputs_drained();
        int waited;
        waited = 0;
        while (cpu_q.size() != 0 || fwd_q.size() != 0) begin
            next_cycle();
            waited++;
            if (waited > WAIT_LIMIT) begin
                stop_with_error("expected output flits never arrived");
            end
        end
        repeat (8) next_cycle();
    endtask

    ////////////////////////////////////////
    // ready and heard drivers

    always @(posedge nocclk) begin
        logic [31:0] rnd;
        #1;
        rnd = $random(ready_seed);
        if (rand_ready) begin
            cpu_flit_ready = rnd[0];
            fwd_flit_ready = rnd[1] | rnd[2];
        end else begin
            cpu_flit_ready = 1'b1;
            fwd_flit_ready = 1'b1;
        end
        heard_tick = heard_tick + 1'b1;
        heard_valid = 1'b0;
        if (keep_6 && heard_tick[2:0] == 3'd0) begin
            heard_valid = 1'b1;
            heard_node_id = 4'd6;
        end else if (keep_9 && heard_tick[2:0] == 3'd4) begin
            heard_valid = 1'b1;
            heard_node_id = 4'd9;
        end
    end

    ////////////////////////////////////////
    // output checks

    always @(negedge nocclk) begin
        flit_t     exp_flit;
        fwd_item_t exp_item;
        if (rst_n) begin
            assert (dut0.asserts0.fail_count == 0) else begin
                stop_with_error("a bound handshake assertion failed");
            end
            if (cpu_flit_valid && cpu_flit_ready) begin
                assert (cpu_q.size() > 0) else begin
                    stop_with_error("a flit left on the CPU port when none was expected");
                end
                exp_flit = cpu_q.pop_front();
                compare_value("cpu_flit", cpu_flit, exp_flit);
            end
            if (fwd_flit_valid && fwd_flit_ready) begin
                assert (fwd_q.size() > 0) else begin
                    stop_with_error("a flit left on the forward port when none was expected");
                end
                exp_item = fwd_q.pop_front();
                compare_value("fwd_flit", fwd_flit, exp_item.flit);
                compare_value("fwd_next_hop", fwd_next_hop, exp_item.hop);
            end
        end
    end

    ////////////////////////////////////////
    // stimulus

    initial begin
        fwd_item_t join_item;
        rst_n = 1'b0;
        in_flit = '0;
        in_flit_valid = 1'b0;
        heard_node_id = '0;
        heard_valid = 1'b0;
        cpu_flit_ready = 1'b1;
        fwd_flit_ready = 1'b1;
        model_joined = 1'b0;
        model_id = node_id_t'(`ROUTER_UNASSIGNED_ID);
        model_parent = node_id_t'(`ROUTER_ROOT_ID);
        model_tab = '0;
        model_alive = '0;
        repeat (16) next_cycle();

        // join request goes out first
        join_item.flit = make_flit(FLIT_JOIN_REQ, node_id_t'(`ROUTER_UNASSIGNED_ID),
                                   node_id_t'(`ROUTER_ROOT_ID), '0);
        join_item.hop = node_id_t'(`ROUTER_ROOT_ID);
        fwd_q.push_back(join_item);
        rst_n = 1'b1;
        compare_value("cpu_flit_valid", cpu_flit_valid, 0);
        compare_value("fwd_flit_valid", fwd_flit_valid, 0);
        compare_value("in_flit_ready", in_flit_ready, 0);
        compare_value("joined", joined, 0);
        compare_value("this_node_id", this_node_id, `ROUTER_UNASSIGNED_ID);
        wait_outputs_drained();

        // data before the ack is dropped
        repeat (3) send_random(1'b0);
        send_flit(make_flit(FLIT_JOIN_ACK, 4'd3, node_id_t'(`ROUTER_UNASSIGNED_ID), 16'd5));
        wait_joined();
        compare_value("this_node_id", this_node_id, 5);
        wait_outputs_drained();

        send_flit(make_flit(FLIT_DATA, 4'd2, 4'd5, 16'hbeef));
        send_flit(make_flit(FLIT_DATA, 4'd2, 4'd11, 16'h1234));
        wait_outputs_drained();

        keep_6 = 1'b1;
        keep_9 = 1'b1;
        install_routes();
        repeat (NUM_RANDOM) send_random(1'b1);
        wait_outputs_drained();

        // back-pressure on both ports
        rand_ready = 1'b1;
        for (int n = 0; n < NUM_RANDOM; n++) begin
            send_random(1'b1);
            repeat ($unsigned($random(seed)) % 3) next_cycle();
        end
        wait_outputs_drained();
        rand_ready = 1'b0;

        // neighbor 9 goes quiet and expires
        install_routes();
        wait_outputs_drained();
        keep_9 = 1'b0;
        repeat (`ROUTER_EXPIRE_CYCLES + 40) next_cycle();
        model_alive[9] = 1'b0;
        for (int d = 0; d < NUM_IDS; d++) begin
            send_flit(make_flit(FLIT_DATA, 4'd1, node_id_t'(d), payload_t'(d * 16'h0101)));
        end
        wait_outputs_drained();

        if (dut0.asserts0.fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+.
router_pkg.sv
join_fsm.sv
neighbor_timer.sv
flit_decoder.sv
route_table.sv
flit_steer.sv
router_node.sv
router_node_asserts.sv
tb_router_node.sv

// ==== Bender.yml ====
package:
  name: router_node

sources:
  - include_dirs:
      - .
    files:
      - router_pkg.sv
      - join_fsm.sv
      - neighbor_timer.sv
      - flit_decoder.sv
      - route_table.sv
      - flit_steer.sv
      - router_node.sv
  - target: test
    include_dirs:
      - .
    files:
      - router_node_asserts.sv
      - tb_router_node.sv
